/* verilog/bus_pkg.sv */
package bus_pkg;

    //----------------------------------------------------------------------
    // Word bus widths
    //----------------------------------------------------------------------
    localparam int DATA_W = 32;             // Bus data word
    localparam int ADDR_W = 16;             // Byte address
    localparam int BE_W   = DATA_W / 8;     // One enable per byte lane

    localparam int TID_W   = 4;
    localparam int QCNT_W  = 4;
    localparam int QBASE_W = 10;            // Matches address bits 15:6

    //----------------------------------------------------------------------
    // Bus field types
    //----------------------------------------------------------------------
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [BE_W-1:0]   be_t;
    typedef logic [7:0]        byte_t;

    // Target select carried with each request
    typedef logic [TID_W-1:0]  tid_t;

    // Buffer queue state
    typedef logic [QCNT_W-1:0]  qcnt_t;
    typedef logic [QBASE_W-1:0] qbase_t;

endpackage

/* verilog/soc_map_pkg.sv */
package soc_map_pkg;
    import bus_pkg::*;

    //----------------------------------------------------------------------
    // Target IDs on the word bus
    //----------------------------------------------------------------------
    localparam tid_t TID_XRAM  = 4'd1;      // External data RAM
    localparam tid_t TID_QREGS = 4'd4;      // Buffer queue registers

    // Processor data map, bit 15 clear is data RAM
    localparam int XRAM_LIMIT_BIT = 15;

    //----------------------------------------------------------------------
    // Queue register block
    //----------------------------------------------------------------------
    // Word offsets, taken from address bits 3:2
    localparam logic [1:0] QREG_TX_BASE = 2'd0;
    localparam logic [1:0] QREG_RX_BASE = 2'd1;
    localparam logic [1:0] QREG_TX_CNT  = 2'd2;
    localparam logic [1:0] QREG_RX_CNT  = 2'd3;

    localparam int NUM_Q = 2;
    localparam int TX_Q  = 0;
    localparam int RX_Q  = 1;

    localparam int    QBASE_LSB = 6;        // Base compares against adr[15:6]
    localparam qcnt_t QCNT_MAX  = 4'd15;    // Counters saturate here

endpackage

/* verilog/wb_if.sv */
`timescale 1ns/1ps

// Word bus, level strobe held until a single cycle ack
interface wb_if
    import bus_pkg::*;
();

    logic  stb;         // Request pending
    logic  we;          // 1 = write
    tid_t  tid;
    addr_t adr;         // Word aligned byte address
    be_t   be;
    word_t wdata;
    word_t rdata;       // Valid in the ack cycle
    logic  ack;

    modport master (
        output stb, we, tid, adr, be, wdata,
        input  rdata, ack
    );

    modport slave (
        input  stb, we, tid, adr, be, wdata,
        output rdata, ack
    );

endinterface

/* verilog/byte_master_bridge.sv */
`timescale 1ns/1ps

module byte_master_bridge
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic  app_clk,
    input  logic  arst_n_i,

    input  logic  risc_stb_i,
    input  logic  risc_we_i,
    input  addr_t risc_adr_i,
    input  byte_t risc_wdata_i,
    output byte_t risc_rdata_o,
    output logic  risc_ack_o,

    wb_if.master  bus
);

    logic [1:0] lane;

    assign lane = risc_adr_i[1:0];

    //----------------------------------------------------------------------
    // Request side, no added cycles
    //----------------------------------------------------------------------
    assign bus.stb   = risc_stb_i;
    assign bus.we    = risc_we_i;
    assign bus.adr   = {risc_adr_i[ADDR_W-1:2], 2'b00};   // Word align
    assign bus.be    = be_t'(1) << lane;                   // One-hot lane
    assign bus.wdata = {BE_W{risc_wdata_i}};               // Byte on every lane

    // Data map, upper half of the space is the queue block
    assign bus.tid = risc_adr_i[XRAM_LIMIT_BIT] ? TID_QREGS : TID_XRAM;

    assign risc_ack_o = bus.ack;

    // Read byte stays put until the next read completes
    always_ff @(posedge app_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            risc_rdata_o <= '0;
        end else if (bus.ack && !risc_we_i) begin
            risc_rdata_o <= bus.rdata[{lane, 3'b000} +: 8];
        end
    end

endmodule

/* verilog/wb_crossbar.sv */
`timescale 1ns/1ps

module wb_crossbar
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic  app_clk,
    input  logic  arst_n_i,

    // External register bus master
    input  logic  ext_reg_cs_i,
    input  logic  ext_reg_wr_i,
    input  tid_t  ext_reg_tid_i,
    input  addr_t ext_reg_addr_i,
    input  word_t ext_reg_wdata_i,
    input  be_t   ext_reg_be_i,
    output word_t ext_reg_rdata_o,
    output logic  ext_reg_ack_o,

    wb_if.slave   bridge,           // Processor data master
    wb_if.master  qreg,             // Queue register target

    // External RAM target
    output logic  wb_xram_stb_o,
    output logic  wb_xram_wr_o,
    output addr_t wb_xram_adr_o,
    output be_t   wb_xram_be_o,
    output word_t wb_xram_wdata_o,
    input  word_t wb_xram_rdata_i,
    input  logic  wb_xram_ack_i
);

    logic  busy_q;                  // One transaction in flight
    logic  gnt_ext_q;               // Current or last grant, 1 = external bus
    logic  dflt_ack_q;
    logic  pick_ext;

    logic  g_we;
    tid_t  g_tid;
    addr_t g_adr;
    be_t   g_be;
    word_t g_wdata;

    logic  sel_xram;
    logic  sel_qreg;
    logic  sel_dflt;
    logic  dflt_stb;
    logic  tgt_ack;
    word_t tgt_rdata;

    //----------------------------------------------------------------------
    // Arbiter, alternates when both masters wait
    //----------------------------------------------------------------------
    assign pick_ext = ext_reg_cs_i & (~bridge.stb | ~gnt_ext_q);

    always_ff @(posedge app_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q    <= 1'b0;
            gnt_ext_q <= 1'b0;
        end else if (!busy_q) begin
            if (ext_reg_cs_i || bridge.stb) begin
                busy_q    <= 1'b1;
                gnt_ext_q <= pick_ext;
            end
        end else if (tgt_ack) begin
            busy_q <= 1'b0;         // Free again at the ack edge
        end
    end

    // Granted request
    assign g_we    = gnt_ext_q ? ext_reg_wr_i    : bridge.we;
    assign g_tid   = gnt_ext_q ? ext_reg_tid_i   : bridge.tid;
    assign g_be    = gnt_ext_q ? ext_reg_be_i    : bridge.be;
    assign g_wdata = gnt_ext_q ? ext_reg_wdata_i : bridge.wdata;
    assign g_adr   = gnt_ext_q ? {ext_reg_addr_i[ADDR_W-1:2], 2'b00} : bridge.adr;

    //----------------------------------------------------------------------
    // Target decode
    //----------------------------------------------------------------------
    assign sel_xram = (g_tid == TID_XRAM);
    assign sel_qreg = (g_tid == TID_QREGS);
    assign sel_dflt = ~sel_xram & ~sel_qreg;   // Unmapped ID

    assign wb_xram_stb_o   = busy_q & sel_xram;
    assign wb_xram_wr_o    = g_we;
    assign wb_xram_adr_o   = g_adr;
    assign wb_xram_be_o    = g_be;
    assign wb_xram_wdata_o = g_wdata;

    assign qreg.stb   = busy_q & sel_qreg;
    assign qreg.we    = g_we;
    assign qreg.tid   = g_tid;
    assign qreg.adr   = g_adr;
    assign qreg.be    = g_be;
    assign qreg.wdata = g_wdata;

    // Unmapped targets answer after one cycle with zero data
    assign dflt_stb = busy_q & sel_dflt;

    always_ff @(posedge app_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dflt_ack_q <= 1'b0;
        end else begin
            dflt_ack_q <= dflt_stb & ~dflt_ack_q;
        end
    end

    // Response back to the granted master only
    assign tgt_ack = busy_q & ((sel_xram & wb_xram_ack_i) |
                               (sel_qreg & qreg.ack) |
                               (sel_dflt & dflt_ack_q));

    assign tgt_rdata = sel_xram ? wb_xram_rdata_i :
                       sel_qreg ? qreg.rdata      : '0;

    assign ext_reg_ack_o   = tgt_ack & gnt_ext_q;
    assign ext_reg_rdata_o = gnt_ext_q ? tgt_rdata : '0;
    assign bridge.ack      = tgt_ack & ~gnt_ext_q;
    assign bridge.rdata    = gnt_ext_q ? '0 : tgt_rdata;

    //----------------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------------
    // Only one target is strobed or answering at a time
    a_one_target: assert property (@(posedge app_clk) disable iff (!arst_n_i)
        $onehot0({wb_xram_stb_o | wb_xram_ack_i, qreg.stb | qreg.ack, dflt_stb | dflt_ack_q}));

    a_ext_hold: assert property (@(posedge app_clk) disable iff (!arst_n_i)
        ext_reg_cs_i && !ext_reg_ack_o |=> ext_reg_cs_i);

endmodule

/* verilog/buf_queue_regs.sv */
`timescale 1ns/1ps

module buf_queue_regs
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic  app_clk,
    input  logic  arst_n_i,

    wb_if.slave   bus,

    // RAM port snoop
    input  logic  xram_stb_i,
    input  logic  xram_wr_i,
    input  addr_t xram_adr_i,
    input  be_t   xram_be_i,
    input  logic  xram_ack_i,

    output logic  tx_q_empty_o,
    output logic  rx_q_empty_o
);

    qbase_t     base_q [NUM_Q];
    qcnt_t      cnt_q  [NUM_Q];
    logic       ack_q;
    logic       wr_en;
    logic [1:0] qofs;
    logic       ram_done;
    logic [NUM_Q-1:0] inc;
    logic [NUM_Q-1:0] dec;

    assign qofs  = bus.adr[3:2];
    assign wr_en = bus.stb & ~ack_q & bus.we;   // Write once, at the first edge

    //----------------------------------------------------------------------
    // Register access
    //----------------------------------------------------------------------
    always_ff @(posedge app_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q        <= 1'b0;
            base_q[TX_Q] <= '0;
            base_q[RX_Q] <= '0;
        end else begin
            ack_q <= bus.stb & ~ack_q;
            if (wr_en && (qofs == QREG_TX_BASE || qofs == QREG_RX_BASE)) begin
                if (bus.be[0]) base_q[qofs == QREG_RX_BASE][7:0] <= bus.wdata[7:0];
                if (bus.be[1]) base_q[qofs == QREG_RX_BASE][9:8] <= bus.wdata[9:8];
            end
        end
    end

    assign bus.ack = ack_q;

    always_comb begin
        case (qofs)
            QREG_TX_BASE: bus.rdata = word_t'(base_q[TX_Q]);
            QREG_RX_BASE: bus.rdata = word_t'(base_q[RX_Q]);
            QREG_TX_CNT:  bus.rdata = word_t'(cnt_q[TX_Q]);
            default:      bus.rdata = word_t'(cnt_q[RX_Q]);   // RX count
        endcase
    end

    //----------------------------------------------------------------------
    // Queue counters, fed by completed RAM accesses on lane 3
    //----------------------------------------------------------------------
    assign ram_done = xram_stb_i & xram_ack_i & xram_be_i[3];

    always_comb begin
        for (int q = 0; q < NUM_Q; q++) begin
            inc[q] = ram_done & xram_wr_i &
                     (xram_adr_i[ADDR_W-1:QBASE_LSB] == base_q[q]);
            dec[q] = ram_done & ~xram_wr_i &
                     (xram_adr_i[ADDR_W-1:QBASE_LSB] == base_q[q]);
        end
    end

    always_ff @(posedge app_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q[TX_Q] <= '0;
            cnt_q[RX_Q] <= '0;
        end else begin
            for (int q = 0; q < NUM_Q; q++) begin
                if (inc[q] && cnt_q[q] != QCNT_MAX) begin
                    cnt_q[q] <= cnt_q[q] + 1'b1;
                end else if (dec[q] && cnt_q[q] != '0) begin
                    cnt_q[q] <= cnt_q[q] - 1'b1;
                end
            end
        end
    end

    assign tx_q_empty_o = (cnt_q[TX_Q] == '0);
    assign rx_q_empty_o = (cnt_q[RX_Q] == '0);

    // Snooped request stays put until the RAM answers
    a_snoop_stable: assert property (@(posedge app_clk) disable iff (!arst_n_i)
        xram_stb_i && !xram_ack_i |=>
            xram_stb_i && $stable({xram_wr_i, xram_adr_i, xram_be_i}));

endmodule

/* verilog/digital_core.sv */
`timescale 1ns/1ps

module digital_core
    import bus_pkg::*;
(
    input  logic  app_clk,
    input  logic  arst_n_i,

    // External register bus
    input  logic  ext_reg_cs_i,
    input  logic  ext_reg_wr_i,
    input  tid_t  ext_reg_tid_i,
    input  addr_t ext_reg_addr_i,
    input  word_t ext_reg_wdata_i,
    input  be_t   ext_reg_be_i,
    output word_t ext_reg_rdata_o,
    output logic  ext_reg_ack_o,

    // Processor data port, byte wide
    input  logic  risc_stb_i,
    input  logic  risc_we_i,
    input  addr_t risc_adr_i,
    input  byte_t risc_wdata_i,
    output byte_t risc_rdata_o,
    output logic  risc_ack_o,

    // External data RAM
    input  word_t wb_xram_rdata_i,
    input  logic  wb_xram_ack_i,
    output logic  wb_xram_stb_o,
    output logic  wb_xram_wr_o,
    output addr_t wb_xram_adr_o,
    output be_t   wb_xram_be_o,
    output word_t wb_xram_wdata_o,

    output logic  tx_q_empty_o,
    output logic  rx_q_empty_o
);

    wb_if bridge_bus ();
    wb_if qreg_bus ();

    byte_master_bridge u_bridge (
        .app_clk         (app_clk),
        .arst_n_i        (arst_n_i),
        .risc_stb_i      (risc_stb_i),
        .risc_we_i       (risc_we_i),
        .risc_adr_i      (risc_adr_i),
        .risc_wdata_i    (risc_wdata_i),
        .risc_rdata_o    (risc_rdata_o),
        .risc_ack_o      (risc_ack_o),
        .bus             (bridge_bus.master)
    );

    wb_crossbar u_crossbar (
        .app_clk         (app_clk),
        .arst_n_i        (arst_n_i),
        .ext_reg_cs_i    (ext_reg_cs_i),
        .ext_reg_wr_i    (ext_reg_wr_i),
        .ext_reg_tid_i   (ext_reg_tid_i),
        .ext_reg_addr_i  (ext_reg_addr_i),
        .ext_reg_wdata_i (ext_reg_wdata_i),
        .ext_reg_be_i    (ext_reg_be_i),
        .ext_reg_rdata_o (ext_reg_rdata_o),
        .ext_reg_ack_o   (ext_reg_ack_o),
        .bridge          (bridge_bus.slave),
        .qreg            (qreg_bus.master),
        .wb_xram_stb_o   (wb_xram_stb_o),
        .wb_xram_wr_o    (wb_xram_wr_o),
        .wb_xram_adr_o   (wb_xram_adr_o),
        .wb_xram_be_o    (wb_xram_be_o),
        .wb_xram_wdata_o (wb_xram_wdata_o),
        .wb_xram_rdata_i (wb_xram_rdata_i),
        .wb_xram_ack_i   (wb_xram_ack_i)
    );

    // Counters watch the RAM port as driven by the crossbar
    buf_queue_regs u_qregs (
        .app_clk         (app_clk),
        .arst_n_i        (arst_n_i),
        .bus             (qreg_bus.slave),
        .xram_stb_i      (wb_xram_stb_o),
        .xram_wr_i       (wb_xram_wr_o),
        .xram_adr_i      (wb_xram_adr_o),
        .xram_be_i       (wb_xram_be_o),
        .xram_ack_i      (wb_xram_ack_i),
        .tx_q_empty_o    (tx_q_empty_o),
        .rx_q_empty_o    (rx_q_empty_o)
    );

endmodule

/* test/tb_digital_core.sv */
`timescale 1ns/1ps

module tb_digital_core
    import bus_pkg::*;
    import soc_map_pkg::*;
();

    localparam int MAX_CYCLES = 4000;   // ~300 transactions at 8 cycles worst case, plus margin
    localparam int RAM_WORDS  = 1 << (ADDR_W - 2);

    logic  app_clk, arst_n_i;
    logic  ext_reg_cs_i, ext_reg_wr_i, ext_reg_ack_o;
    tid_t  ext_reg_tid_i;
    addr_t ext_reg_addr_i;
    word_t ext_reg_wdata_i, ext_reg_rdata_o;
    be_t   ext_reg_be_i;
    logic  risc_stb_i, risc_we_i, risc_ack_o;
    addr_t risc_adr_i;
    byte_t risc_wdata_i, risc_rdata_o;
    word_t wb_xram_rdata_i, wb_xram_wdata_o;
    logic  wb_xram_ack_i, wb_xram_stb_o, wb_xram_wr_o;
    addr_t wb_xram_adr_o;
    be_t   wb_xram_be_o;
    logic  tx_q_empty_o, rx_q_empty_o;

    word_t       ram [RAM_WORDS];           // RAM model storage
    word_t       shadow_mem [RAM_WORDS];    // Reference copy
    qbase_t      shadow_base [NUM_Q];
    qcnt_t       shadow_cnt [NUM_Q];
    int          ram_wait = -1;             // -1 while the RAM is idle
    int unsigned cycle_cnt = 0;
    string       test_name = "reset";
    word_t       ext_exp;
    byte_t       risc_exp;
    logic        risc_rd_pend = 1'b0;

    digital_core uut (.*);

    always #50 app_clk = ~app_clk;

    //----------------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------------
    function automatic word_t fill_word(input int idx);
        return {idx[15:0] ^ 16'hA5C3, idx[15:0]};
    endfunction

    function automatic addr_t qreg_adr(input logic [1:0] ofs);
        return {12'd0, ofs, 2'b00};
    endfunction

    // Returns the expected read word and updates the shadow state
    function automatic word_t ref_model(input logic wr, input tid_t tid, input addr_t adr,
                                        input be_t be, input word_t wd);
        word_t      rd;
        word_t      cur;
        logic [1:0] ofs;
        rd  = '0;
        ofs = adr[3:2];
        if (tid == TID_XRAM) begin
            cur = shadow_mem[adr[15:2]];
            for (int b = 0; b < BE_W; b++) begin
                if (wr && be[b]) cur[b*8 +: 8] = wd[b*8 +: 8];
            end
            shadow_mem[adr[15:2]] = cur;
            rd = wr ? '0 : cur;
            for (int q = 0; q < NUM_Q; q++) begin
                if (be[3] && adr[15:6] == shadow_base[q]) begin
                    if (wr && shadow_cnt[q] != QCNT_MAX) shadow_cnt[q] = shadow_cnt[q] + 1'b1;
                    if (!wr && shadow_cnt[q] != '0) shadow_cnt[q] = shadow_cnt[q] - 1'b1;
                end
            end
        end else if (tid == TID_QREGS) begin
            if (wr && (ofs == QREG_TX_BASE || ofs == QREG_RX_BASE)) begin
                if (be[0]) shadow_base[ofs[0]][7:0] = wd[7:0];
                if (be[1]) shadow_base[ofs[0]][9:8] = wd[9:8];
            end
            case (ofs)
                QREG_TX_BASE: rd = word_t'(shadow_base[TX_Q]);
                QREG_RX_BASE: rd = word_t'(shadow_base[RX_Q]);
                QREG_TX_CNT:  rd = word_t'(shadow_cnt[TX_Q]);
                default:      rd = word_t'(shadow_cnt[RX_Q]);
            endcase
        end
        return rd;                          // Unmapped IDs read zero
    endfunction

    //----------------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------------
    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "Stopped at the first wrong word");
        end
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "Stopped at the first wrong byte");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "Stopped at the first wrong flag");
        end
    endtask

    // Read data compared in the ack cycle, processor byte one edge later
    always @(posedge app_clk) begin
        if (ext_reg_ack_o && !ext_reg_wr_i) begin
            check_word(test_name, ext_exp, ext_reg_rdata_o);
        end
        if (risc_rd_pend) begin
            check_byte(test_name, risc_exp, risc_rdata_o);
        end
        risc_rd_pend <= risc_ack_o & ~risc_we_i;
    end

    always @(posedge app_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // RAM model, 0 to 3 wait cycles per access
    always @(negedge app_clk) begin
        if (wb_xram_ack_i) begin
            wb_xram_ack_i = 1'b0;
        end else if (wb_xram_stb_o) begin
            if (ram_wait < 0) ram_wait = int'($urandom % 4);
            if (ram_wait == 0) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (wb_xram_wr_o && wb_xram_be_o[b]) begin
                        ram[wb_xram_adr_o[15:2]][b*8 +: 8] = wb_xram_wdata_o[b*8 +: 8];
                    end
                end
                wb_xram_rdata_i = ram[wb_xram_adr_o[15:2]];
                wb_xram_ack_i   = 1'b1;
            end
            ram_wait = ram_wait - 1;
        end
    end

    //----------------------------------------------------------------------
    // Bus masters
    //----------------------------------------------------------------------
    task automatic ext_access(input logic wr, input tid_t tid, input addr_t adr,
                              input be_t be, input word_t wd);
        @(negedge app_clk);
        ext_exp         = ref_model(wr, tid, adr, be, wd);
        ext_reg_cs_i    = 1'b1;
        ext_reg_wr_i    = wr;
        ext_reg_tid_i   = tid;
        ext_reg_addr_i  = adr;
        ext_reg_be_i    = be;
        ext_reg_wdata_i = wd;
        @(posedge app_clk);
        while (!ext_reg_ack_o) @(posedge app_clk);
        @(negedge app_clk);
        ext_reg_cs_i = 1'b0;
    endtask

    task automatic risc_access(input logic wr, input addr_t adr, input byte_t wd);
        word_t exp_w;
        be_t   be;
        tid_t  tid;
        be  = be_t'(4'b0001 << adr[1:0]);
        tid = adr[XRAM_LIMIT_BIT] ? TID_QREGS : TID_XRAM;
        @(negedge app_clk);
        exp_w        = ref_model(wr, tid, adr, be, {BE_W{wd}});
        risc_exp     = byte_t'(exp_w >> (8 * adr[1:0]));
        risc_stb_i   = 1'b1;
        risc_we_i    = wr;
        risc_adr_i   = adr;
        risc_wdata_i = wd;
        @(posedge app_clk);
        while (!risc_ack_o) @(posedge app_clk);
        @(negedge app_clk);
        risc_stb_i = 1'b0;
    endtask

    task automatic verify_queues;
        ext_access(1'b0, TID_QREGS, qreg_adr(QREG_TX_CNT), 4'hF, '0);
        ext_access(1'b0, TID_QREGS, qreg_adr(QREG_RX_CNT), 4'hF, '0);
        check_flag(test_name, shadow_cnt[TX_Q] == '0, tx_q_empty_o);
        check_flag(test_name, shadow_cnt[RX_Q] == '0, rx_q_empty_o);
    endtask

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------
    initial begin
        logic  e_wr;
        tid_t  e_tid;
        addr_t e_adr;
        logic  r_wr;
        addr_t r_adr;
        void'($urandom(32'h742c_9a9d));
        app_clk = 1'b0;
        arst_n_i = 1'b0;
        {ext_reg_cs_i, ext_reg_wr_i, ext_reg_tid_i, ext_reg_addr_i} = '0;
        {ext_reg_wdata_i, ext_reg_be_i} = '0;
        {risc_stb_i, risc_we_i, risc_adr_i, risc_wdata_i} = '0;
        wb_xram_rdata_i = '0;
        wb_xram_ack_i   = 1'b0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i]        = fill_word(i);
            shadow_mem[i] = fill_word(i);
        end
        shadow_base = '{default: '0};
        shadow_cnt  = '{default: '0};
        repeat (3) @(negedge app_clk);
        arst_n_i = 1'b1;

        check_flag(test_name, 1'b0, ext_reg_ack_o);
        check_flag(test_name, 1'b0, risc_ack_o);
        check_flag(test_name, 1'b0, wb_xram_stb_o);
        verify_queues();

        test_name = "queue registers";
        for (int i = 0; i < 4; i++) begin
            ext_access(1'b1, TID_QREGS, qreg_adr(2'(i)), 4'hF, $urandom);
            ext_access(1'b0, TID_QREGS, qreg_adr(2'(i)), 4'hF, '0);
        end
        ext_access(1'b1, TID_QREGS, qreg_adr(QREG_RX_BASE), 4'b0010, 32'hFFFF_FFFF);
        ext_access(1'b0, TID_QREGS, qreg_adr(QREG_RX_BASE), 4'hF, '0);

        test_name = "ram bytes";
        for (int i = 0; i < 40; i++) begin
            r_adr = addr_t'($urandom % 32768);
            risc_access(1'b1, r_adr, byte_t'($urandom));
            risc_access(1'b0, r_adr, '0);
            ext_access(1'b0, TID_XRAM, r_adr, 4'hF, '0);
        end

        test_name = "queue counters";
        ext_access(1'b1, TID_QREGS, qreg_adr(QREG_TX_BASE), 4'h3, 32'h10);   // Window 0x0400
        ext_access(1'b1, TID_QREGS, qreg_adr(QREG_RX_BASE), 4'h3, 32'h11);   // Window 0x0440
        verify_queues();
        for (int i = 0; i < 17; i++) begin
            ext_access(1'b1, TID_XRAM, addr_t'(16'h0400 + 4 * (i % 16)), 4'hF, $urandom);
        end
        verify_queues();
        for (int i = 0; i < 3; i++) begin
            risc_access(1'b1, 16'h0440, byte_t'($urandom));      // Lane 0, no count
            risc_access(1'b1, 16'h0447, byte_t'($urandom));
        end
        ext_access(1'b1, TID_XRAM, 16'h0444, 4'h7, $urandom);
        ext_access(1'b1, TID_XRAM, 16'h0480, 4'hF, $urandom);    // Outside both windows
        verify_queues();
        for (int i = 0; i < 18; i++) begin
            if (i % 2 == 0) begin
                risc_access(1'b0, addr_t'(16'h0403 + 4 * (i % 16)), '0);
            end else begin
                ext_access(1'b0, TID_XRAM, addr_t'(16'h0400 + 4 * (i % 16)), 4'hF, '0);
            end
        end
        for (int i = 0; i < 4; i++) begin
            ext_access(1'b0, TID_XRAM, 16'h0440, 4'hF, '0);
        end
        verify_queues();

        // Both masters at once, disjoint RAM regions and no queue hits
        test_name = "concurrent masters";
        ext_access(1'b1, TID_QREGS, qreg_adr(QREG_TX_BASE), 4'h3, 32'h3F0);
        ext_access(1'b1, TID_QREGS, qreg_adr(QREG_RX_BASE), 4'h3, 32'h3F0);
        for (int i = 0; i < 60; i++) begin
            case ($urandom % 4)
                0: begin
                    e_wr  = 1'b1;
                    e_tid = TID_XRAM;
                end
                1: begin
                    e_wr  = 1'b0;
                    e_tid = TID_XRAM;
                end
                2: begin
                    e_wr  = 1'b0;
                    e_tid = TID_QREGS;
                end
                default: begin
                    e_wr  = 1'($urandom % 2);
                    e_tid = tid_t'(8 + $urandom % 8);
                end
            endcase
            e_adr = addr_t'($urandom % 4096);
            r_wr  = 1'($urandom % 2);
            if ($urandom % 3 == 0) begin
                r_adr = addr_t'(16'h8000 + $urandom % 16);        // Queue block, read only
                r_wr  = 1'b0;
            end else begin
                r_adr = addr_t'(16'h1000 + $urandom % 4096);
            end
            fork
                ext_access(e_wr, e_tid, e_adr, be_t'($urandom), $urandom);
                risc_access(r_wr, r_adr, byte_t'($urandom));
            join
        end

        test_name = "unmapped target";
        for (int t = 0; t < 16; t++) begin
            if (tid_t'(t) != TID_XRAM && tid_t'(t) != TID_QREGS) begin
                ext_access(1'b1, tid_t'(t), addr_t'($urandom), 4'hF, $urandom);
                ext_access(1'b0, tid_t'(t), addr_t'($urandom), 4'hF, '0);
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* tb.f */
verilog/bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/wb_if.sv
verilog/byte_master_bridge.sv
verilog/wb_crossbar.sv
verilog/buf_queue_regs.sv
verilog/digital_core.sv
test/tb_digital_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_digital_core -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Finished with no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
